/* pcm_player.f */
logic/pcm_pkg.sv
logic/sdram_arbiter.sv
logic/sd_loader.sv
logic/i2s_reader.sv
logic/pcm_player_top.sv
bench/tb_models.sv
bench/tb_pcm_player.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pcm_player testbench, then decide from the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_pcm_player \
	-f pcm_player.f -o sim_pcm_player > build.log 2>&1 &&
	./obj_dir/sim_pcm_player > sim.log 2>&1
grep -q "STATUS: PASS" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }

/* bench/tb_pcm_player.sv */
`timescale 1ns/1ps

module tb_pcm_player;

	localparam int LOAD_CYCLES = pcm_pkg::LOAD_WORDS * (pcm_pkg::DATA_W * 2 * pcm_pkg::SPI_DIV + 16);
	localparam int PLAY_CYCLES = (pcm_pkg::LOAD_WORDS + 2) * pcm_pkg::DATA_W * 2 * pcm_pkg::BCLK_DIV;
	localparam int IDLE_CYCLES = 200;
	localparam int TIMEOUT_CYCLES = 2 * (LOAD_CYCLES + 2 * PLAY_CYCLES + 2 * IDLE_CYCLES + 200);

	logic                        clk;
	logic                        reset;
	logic                        new_frame;
	logic [pcm_pkg::ADDR_W-1:0]  mem_addr;
	logic [1:0]                  mem_be;
	logic                        mem_read;
	logic                        mem_write;
	logic [pcm_pkg::DATA_W-1:0]  mem_wdata;
	logic                        mem_ack;
	logic [pcm_pkg::DATA_W-1:0]  mem_rdata;
	logic                        sd_cs;
	logic                        sd_sclk;
	logic                        sd_mosi;
	logic                        sd_miso;
	logic                        card_miso;
	logic                        miso_force_en;	// bench drives card miso directly
	logic                        miso_force_val;
	logic                        host_cs_n;
	logic                        host_sclk;
	logic                        host_mosi;
	logic                        host_miso;
	logic                        i2s_bclk;
	logic                        i2s_lrclk;
	logic                        i2s_sd;

	logic [pcm_pkg::DATA_W-1:0]  captured [$];
	logic                        captured_lr [$];	// lrclk level of each captured word
	logic [pcm_pkg::DATA_W-1:0]  cap_word;
	logic                        last_lrclk;
	int                          cap_bits;
	int                          cycle_count;
	int                          error_count;

	assign sd_miso = miso_force_en ? miso_force_val : card_miso;

	pcm_player_top u_dut
	(
		.clk         (clk),
		.reset       (reset),
		.new_frame_i (new_frame),
		.mem_addr_o  (mem_addr),
		.mem_be_o    (mem_be),
		.mem_read_o  (mem_read),
		.mem_write_o (mem_write),
		.mem_wdata_o (mem_wdata),
		.mem_ack_i   (mem_ack),
		.mem_rdata_i (mem_rdata),
		.sd_cs_o     (sd_cs),
		.sd_sclk_o   (sd_sclk),
		.sd_mosi_o   (sd_mosi),
		.sd_miso_i   (sd_miso),
		.host_cs_n_i (host_cs_n),
		.host_sclk_i (host_sclk),
		.host_mosi_i (host_mosi),
		.host_miso_o (host_miso),
		.i2s_bclk_o  (i2s_bclk),
		.i2s_lrclk_o (i2s_lrclk),
		.i2s_sd_o    (i2s_sd)
	);

	mem_model u_mem
	(
		.clk     (clk),
		.reset   (reset),
		.addr_i  (mem_addr),
		.read_i  (mem_read),
		.write_i (mem_write),
		.wdata_i (mem_wdata),
		.ack_o   (mem_ack),
		.rdata_o (mem_rdata)
	);

	sd_card_model u_card
	(
		.cs_i   (sd_cs),
		.sclk_i (sd_sclk),
		.miso_o (card_miso)
	);

	always #10 clk = !clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	end

	// i2s capture, lrclk edge restarts the word
	always @(posedge i2s_bclk or posedge i2s_lrclk or negedge i2s_lrclk)
	begin
		if (i2s_lrclk != last_lrclk)
		begin
			cap_bits = 0;
			last_lrclk = i2s_lrclk;
		end
		else
		begin
			cap_word = {cap_word[pcm_pkg::DATA_W-2:0], i2s_sd};
			cap_bits = cap_bits + 1;
			if (cap_bits == pcm_pkg::DATA_W)
			begin
				captured.push_back(cap_word);
				captured_lr.push_back(i2s_lrclk);
				cap_bits = 0;
			end
		end
	end

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			error_count++;
			$display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic pulse_frame();
		@(negedge clk);
		new_frame = 1'b1;
		@(negedge clk);
		new_frame = 1'b0;
	endtask

	task automatic test_reset_state();
		#1;
		check_value("reset mem_read", 0, mem_read);
		check_value("reset mem_write", 0, mem_write);
		check_value("reset loader wait", 1, u_dut.ld_wait);
		check_value("reset reader wait", 1, u_dut.rd_wait);
		check_value("reset sd_cs", 1, sd_cs);
		check_value("reset i2s", 0, {i2s_bclk, i2s_lrclk, i2s_sd});
		wait_cycles(10);
		#1;
		check_value("no load before frame", 0, u_mem.write_count);
		check_value("card idle before frame", 1, sd_cs);
	endtask

	task automatic test_load();
		int sclk_low_seen;
		sclk_low_seen = 0;
		pulse_frame();
		wait_cycles(6);
		host_sclk = 1'b1;
		// host pins wiggle while the loader owns the card
		for (int i = 0; i < 100; i++)
		begin
			@(negedge clk);
			host_cs_n = i[0];
			host_mosi = i[1];
			#1;
			check_value("load host_miso", 0, host_miso);
			check_value("load sd_cs", 0, sd_cs);
			check_value("load sd_mosi", 1, sd_mosi);
			check_value("load mem_be", 2'b11, mem_be);	// whole words only
			if (!sd_sclk)
				sclk_low_seen = 1;
		end
		check_value("load sd_sclk not from host", 1, sclk_low_seen);
		host_cs_n = 1'b1;
		host_sclk = 1'b0;
		host_mosi = 1'b1;
		while (u_mem.write_count < pcm_pkg::LOAD_WORDS)
			@(negedge clk);
		wait_cycles(4);
		check_value("load write count", pcm_pkg::LOAD_WORDS, u_mem.write_count);
		check_value("load writes out of range", 0, u_mem.oob_writes);
		for (int i = 0; i < pcm_pkg::LOAD_WORDS; i++)
			check_value($sformatf("load word %0d", i), u_card.words[i], u_mem.mem[i]);
		$display("load done, arbiter phase %0d", u_dut.u_arbiter.phase_q);
	endtask

	task automatic test_host_passthrough();
		logic [3:0] pins;
		miso_force_en = 1'b1;
		for (int i = 0; i < 16; i++)
		begin
			pins = 4'(i);
			@(negedge clk);
			host_cs_n = pins[0];
			host_sclk = pins[1];
			host_mosi = pins[2];
			miso_force_val = pins[3];
			#1;
			check_value("host sd_cs", pins[0], sd_cs);
			check_value("host sd_sclk", pins[1], sd_sclk);
			check_value("host sd_mosi", pins[2], sd_mosi);
			check_value("host miso", pins[3], host_miso);
		end
		@(negedge clk);
		host_cs_n = 1'b1;
		host_sclk = 1'b0;
		host_mosi = 1'b1;
		miso_force_en = 1'b0;
	endtask

	task automatic test_idle(input string test_name, input int n);
		int reads_before;
		reads_before = u_mem.read_count;
		repeat (n)
		begin
			@(negedge clk);
			#1;
			check_value({test_name, " mem_read"}, 0, mem_read);
			check_value({test_name, " i2s_sd"}, 0, i2s_sd);
		end
		check_value({test_name, " read count"}, reads_before, u_mem.read_count);
	endtask

	task automatic test_play(input string test_name);
		int reads_before;
		logic lr_start;
		captured.delete();
		captured_lr.delete();
		reads_before = u_mem.read_count;
		lr_start = i2s_lrclk;
		pulse_frame();
		while (captured.size() < pcm_pkg::LOAD_WORDS)
			@(negedge clk);
		wait_cycles(40);	// let done reach the arbiter
		check_value({test_name, " words captured"}, pcm_pkg::LOAD_WORDS, captured.size());
		for (int i = 0; i < pcm_pkg::LOAD_WORDS; i++)
		begin
			check_value($sformatf("%s word %0d", test_name, i), u_card.words[i], captured[i]);
			// lrclk toggles at every sample start
			check_value($sformatf("%s lrclk %0d", test_name, i),
				(i % 2 == 0) ? !lr_start : lr_start, captured_lr[i]);
		end
		check_value({test_name, " read count"}, pcm_pkg::LOAD_WORDS,
			u_mem.read_count - reads_before);
		check_value({test_name, " reads out of range"}, 0, u_mem.oob_reads);
		for (int i = 0; i < pcm_pkg::LOAD_WORDS; i++)
			check_value($sformatf("%s read address %0d", test_name, i), i,
				u_mem.read_log[(reads_before + i) % 1024]);
		$display("%s done, arbiter phase %0d", test_name, u_dut.u_arbiter.phase_q);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		new_frame = 1'b0;
		host_cs_n = 1'b1;
		host_sclk = 1'b0;
		host_mosi = 1'b1;
		miso_force_en = 1'b0;
		miso_force_val = 1'b0;
		cap_word = '0;
		cap_bits = 0;
		last_lrclk = 1'b0;
		cycle_count = 0;
		error_count = 0;

		repeat (5) @(negedge clk);
		reset = 1'b0;

		test_reset_state();
		test_load();
		test_host_passthrough();
		test_idle("idle before play", IDLE_CYCLES);
		test_play("playback");
		test_idle("idle after playback", IDLE_CYCLES);
		test_play("replay");

		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* bench/tb_models.sv */
`timescale 1ns/1ps

module mem_model
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic [pcm_pkg::ADDR_W-1:0]  addr_i,
	input  logic                        read_i,
	input  logic                        write_i,
	input  logic [pcm_pkg::DATA_W-1:0]  wdata_i,
	output logic                        ack_o,
	output logic [pcm_pkg::DATA_W-1:0]  rdata_o
);

	logic [pcm_pkg::DATA_W-1:0]  mem [0:255];
	logic [pcm_pkg::ADDR_W-1:0]  read_log [0:1023];	// address of every read, in order
	logic [31:0]                 rnd;
	logic                        busy;
	logic [2:0]                  delay_cnt;
	logic                        in_range;
	int                          write_count;
	int                          read_count;
	int                          oob_writes;
	int                          oob_reads;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign in_range = (addr_i < 25'd256);

	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = 16'(i) ^ 16'hc3c3;	// distinct per address
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			ack_o <= 1'b0;
			rdata_o <= '0;
			busy <= 1'b0;
			delay_cnt <= '0;
			rnd <= 32'h6c97;
			write_count <= 0;
			read_count <= 0;
			oob_writes <= 0;
			oob_reads <= 0;
		end
		else if (ack_o)
		begin
			// acknowledge cycle, request still held by the master
			ack_o <= 1'b0;
			busy <= 1'b0;
			if (write_i)
			begin
				if (in_range)
					mem[addr_i[7:0]] <= wdata_i;
				else
					oob_writes <= oob_writes + 1;
				write_count <= write_count + 1;
			end
			if (read_i)
			begin
				read_log[read_count[9:0]] <= addr_i;
				if (!in_range)
					oob_reads <= oob_reads + 1;
				read_count <= read_count + 1;
			end
		end
		else if (read_i || write_i)
		begin
			if (!busy)
			begin
				busy <= 1'b1;
				rnd <= next_random(rnd);
				delay_cnt <= rnd[2:0];	// 1 to 8 cycles until ack
			end
			else if (delay_cnt == 3'd0)
			begin
				ack_o <= 1'b1;
				rdata_o <= in_range ? mem[addr_i[7:0]] : 16'hdead;
			end
			else
				delay_cnt <= delay_cnt - 3'd1;
		end
	end

endmodule

module sd_card_model
(
	input  logic  cs_i,
	input  logic  sclk_i,
	output logic  miso_o
);

	logic [pcm_pkg::DATA_W-1:0]  words [0:pcm_pkg::LOAD_WORDS-1];
	logic [31:0]                 rnd;
	logic                        last_cs;
	int                          word_idx;
	int                          bit_idx;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial
	begin
		rnd = 32'h6c97;
		for (int i = 0; i < pcm_pkg::LOAD_WORDS; i++)
		begin
			rnd = next_random(rnd);
			words[i] = rnd[15:0];
		end
		last_cs = 1'b1;
		word_idx = 0;
		bit_idx = pcm_pkg::DATA_W - 1;
	end

	// stream restarts on select, next bit goes out on falling sclk
	always @(posedge cs_i or negedge cs_i or negedge sclk_i)
	begin
		if (last_cs && !cs_i)
		begin
			word_idx = 0;
			bit_idx = pcm_pkg::DATA_W - 1;
		end
		else if (!cs_i)
		begin
			if (bit_idx == 0)
			begin
				bit_idx = pcm_pkg::DATA_W - 1;
				word_idx = word_idx + 1;
			end
			else
				bit_idx = bit_idx - 1;
		end
		last_cs = cs_i;
	end

	assign miso_o = (word_idx < pcm_pkg::LOAD_WORDS) ? words[word_idx][bit_idx] : 1'b1;

endmodule

/* logic/pcm_player_top.sv */
`timescale 1ns/1ps

module pcm_player_top
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        new_frame_i,

	// external memory
	output logic [pcm_pkg::ADDR_W-1:0]  mem_addr_o,
	output logic [1:0]                  mem_be_o,
	output logic                        mem_read_o,
	output logic                        mem_write_o,
	output logic [pcm_pkg::DATA_W-1:0]  mem_wdata_o,
	input  logic                        mem_ack_i,
	input  logic [pcm_pkg::DATA_W-1:0]  mem_rdata_i,

	// sd card
	output logic                        sd_cs_o,
	output logic                        sd_sclk_o,
	output logic                        sd_mosi_o,
	input  logic                        sd_miso_i,

	// host spi
	input  logic                        host_cs_n_i,
	input  logic                        host_sclk_i,
	input  logic                        host_mosi_i,
	output logic                        host_miso_o,

	// i2s out
	output logic                        i2s_bclk_o,
	output logic                        i2s_lrclk_o,
	output logic                        i2s_sd_o
);

	logic [pcm_pkg::ADDR_W-1:0]  ld_addr;
	logic                        ld_write;
	logic [pcm_pkg::DATA_W-1:0]  ld_wdata;
	logic                        ld_done;
	logic                        ld_cs;
	logic                        ld_sclk;
	logic                        ld_mosi;
	logic                        ld_miso;
	logic                        ld_wait;
	logic                        ld_ack;

	logic [pcm_pkg::ADDR_W-1:0]  rd_addr;
	logic                        rd_read;
	logic                        rd_done;
	logic                        rd_wait;
	logic                        rd_ack;
	logic [pcm_pkg::DATA_W-1:0]  rd_data;

	sdram_arbiter u_arbiter
	(
		.clk         (clk),
		.reset       (reset),
		.new_frame_i (new_frame_i),
		.ld_addr_i   (ld_addr),
		.ld_write_i  (ld_write),
		.ld_wdata_i  (ld_wdata),
		.ld_done_i   (ld_done),
		.ld_cs_i     (ld_cs),
		.ld_sclk_i   (ld_sclk),
		.ld_mosi_i   (ld_mosi),
		.ld_wait_o   (ld_wait),
		.ld_ack_o    (ld_ack),
		.ld_miso_o   (ld_miso),
		.rd_addr_i   (rd_addr),
		.rd_read_i   (rd_read),
		.rd_done_i   (rd_done),
		.rd_wait_o   (rd_wait),
		.rd_ack_o    (rd_ack),
		.rd_data_o   (rd_data),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i),
		.mem_addr_o  (mem_addr_o),
		.mem_be_o    (mem_be_o),
		.mem_read_o  (mem_read_o),
		.mem_write_o (mem_write_o),
		.mem_wdata_o (mem_wdata_o),
		.host_cs_n_i (host_cs_n_i),
		.host_sclk_i (host_sclk_i),
		.host_mosi_i (host_mosi_i),
		.host_miso_o (host_miso_o),
		.sd_miso_i   (sd_miso_i),
		.sd_cs_o     (sd_cs_o),
		.sd_sclk_o   (sd_sclk_o),
		.sd_mosi_o   (sd_mosi_o)
	);

	sd_loader u_loader
	(
		.clk     (clk),
		.reset   (reset),
		.wait_i  (ld_wait),
		.ack_i   (ld_ack),
		.miso_i  (ld_miso),
		.addr_o  (ld_addr),
		.write_o (ld_write),
		.wdata_o (ld_wdata),
		.done_o  (ld_done),
		.cs_o    (ld_cs),
		.sclk_o  (ld_sclk),
		.mosi_o  (ld_mosi)
	);

	i2s_reader u_reader
	(
		.clk     (clk),
		.reset   (reset),
		.wait_i  (rd_wait),
		.ack_i   (rd_ack),
		.data_i  (rd_data),
		.addr_o  (rd_addr),
		.read_o  (rd_read),
		.done_o  (rd_done),
		.bclk_o  (i2s_bclk_o),
		.lrclk_o (i2s_lrclk_o),
		.sd_o    (i2s_sd_o)
	);

endmodule

/* logic/i2s_reader.sv */
`timescale 1ns/1ps

module i2s_reader
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        wait_i,
	input  logic                        ack_i,
	input  logic [pcm_pkg::DATA_W-1:0]  data_i,
	output logic [pcm_pkg::ADDR_W-1:0]  addr_o,
	output logic                        read_o,
	output logic                        done_o,
	output logic                        bclk_o,
	output logic                        lrclk_o,
	output logic                        sd_o
);

	logic                                       running;	// bit clock active
	logic                                       hold_valid;
	logic [pcm_pkg::DATA_W-1:0]                 hold_q;	// next word, fetched ahead
	logic [pcm_pkg::DATA_W-1:0]                 shift_q;
	logic [$clog2(pcm_pkg::BCLK_DIV)-1:0]       div_cnt;
	logic [$clog2(pcm_pkg::DATA_W)-1:0]         bit_cnt;
	logic [$clog2(pcm_pkg::LOAD_WORDS+1)-1:0]   word_cnt;	// words played so far
	logic                                       bclk_fall;
	logic                                       slot_end;
	logic                                       first_start;
	logic                                       sample_start;
	logic                                       finish;

	assign bclk_fall = running && bclk_o && (div_cnt == pcm_pkg::BCLK_DIV - 1);
	assign slot_end = bclk_fall && (bit_cnt == pcm_pkg::DATA_W - 1);
	// first slot waits for word 0 so playback never begins on a miss
	assign first_start = !running && !wait_i && hold_valid && (word_cnt == '0);
	assign sample_start = first_start || (slot_end && (word_cnt != pcm_pkg::LOAD_WORDS));
	assign finish = slot_end && (word_cnt == pcm_pkg::LOAD_WORDS);

	assign sd_o = shift_q[pcm_pkg::DATA_W-1];

	always_ff @(posedge clk)
	begin
		if (read_o && ack_i)
			hold_q <= data_i;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			hold_valid <= 1'b0;
			read_o <= 1'b0;
			addr_o <= '0;
			word_cnt <= '0;
			bit_cnt <= '0;
			div_cnt <= '0;
			bclk_o <= 1'b0;
			lrclk_o <= 1'b0;
			shift_q <= '0;
			done_o <= 1'b0;
		end
		else if (wait_i)
		begin
			// not playing, rewind so the next play starts at word 0
			running <= 1'b0;
			hold_valid <= 1'b0;
			read_o <= 1'b0;
			addr_o <= '0;
			word_cnt <= '0;
			bit_cnt <= '0;
			div_cnt <= '0;
			bclk_o <= 1'b0;
			shift_q <= '0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;

			// fetch one word ahead
			if (read_o)
			begin
				if (ack_i)
				begin
					read_o <= 1'b0;
					hold_valid <= 1'b1;
					addr_o <= addr_o + 1'b1;
				end
			end
			else if (!hold_valid && (addr_o < pcm_pkg::LOAD_WORDS))
				read_o <= 1'b1;

			if (running)
			begin
				if (div_cnt == pcm_pkg::BCLK_DIV - 1)
				begin
					div_cnt <= '0;
					bclk_o <= !bclk_o;
				end
				else
					div_cnt <= div_cnt + 1'b1;
			end

			if (bclk_fall)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				shift_q <= {shift_q[pcm_pkg::DATA_W-2:0], 1'b0};	// next bit on falling bclk
			end

			if (sample_start)
			begin
				running <= 1'b1;
				lrclk_o <= !lrclk_o;
				bit_cnt <= '0;
				if (hold_valid)
				begin
					shift_q <= hold_q;
					hold_valid <= 1'b0;
					word_cnt <= word_cnt + 1'b1;
				end
				else
					shift_q <= '0;	// read too late, silent slot and retry
			end

			if (finish)
			begin
				running <= 1'b0;
				done_o <= 1'b1;
			end
		end
	end

endmodule

/* logic/sd_loader.sv */
`timescale 1ns/1ps

module sd_loader
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        wait_i,
	input  logic                        ack_i,
	input  logic                        miso_i,
	output logic [pcm_pkg::ADDR_W-1:0]  addr_o,
	output logic                        write_o,
	output logic [pcm_pkg::DATA_W-1:0]  wdata_o,
	output logic                        done_o,
	output logic                        cs_o,
	output logic                        sclk_o,
	output logic                        mosi_o
);

	logic                                 wait_q;
	logic                                 shifting;	// clocking bits out of the card
	logic                                 word_ready;	// word shifted in, write not yet issued
	logic [$clog2(pcm_pkg::SPI_DIV)-1:0]  div_cnt;
	logic [$clog2(pcm_pkg::DATA_W)-1:0]   bit_cnt;
	logic [pcm_pkg::DATA_W-1:0]           shift_q;
	logic                                 half_end;
	logic                                 sample_en;

	// card streams data with mosi held high
	assign mosi_o = 1'b1;

	assign half_end = shifting && (div_cnt == pcm_pkg::SPI_DIV - 1);
	assign sample_en = half_end && !sclk_o;	// sclk about to rise

	assign wdata_o = shift_q;	// stable while the write is pending

	always_ff @(posedge clk)
	begin
		if (sample_en)
			shift_q <= {shift_q[pcm_pkg::DATA_W-2:0], miso_i};	// msb first
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wait_q <= 1'b1;
			shifting <= 1'b0;
			word_ready <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			addr_o <= '0;
			write_o <= 1'b0;
			done_o <= 1'b0;
			cs_o <= 1'b1;
			sclk_o <= 1'b0;
		end
		else
		begin
			wait_q <= wait_i;
			done_o <= 1'b0;

			if (!wait_i && wait_q)
			begin
				// loading granted, select card and start word 0
				cs_o <= 1'b0;
				shifting <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
				addr_o <= '0;
			end
			else if (shifting)
			begin
				if (half_end)
				begin
					div_cnt <= '0;
					sclk_o <= !sclk_o;
					if (sclk_o)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						// stop after the falling edge of the last bit
						if (bit_cnt == pcm_pkg::DATA_W - 1)
						begin
							shifting <= 1'b0;
							word_ready <= 1'b1;
						end
					end
				end
				else
					div_cnt <= div_cnt + 1'b1;
			end
			else if (word_ready && !wait_i)
			begin
				word_ready <= 1'b0;
				write_o <= 1'b1;
			end
			else if (write_o && ack_i)
			begin
				write_o <= 1'b0;
				if (addr_o == pcm_pkg::LOAD_WORDS - 1)
				begin
					cs_o <= 1'b1;	// block complete
					done_o <= 1'b1;
				end
				else
				begin
					addr_o <= addr_o + 1'b1;
					shifting <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/sdram_arbiter.sv */
`timescale 1ns/1ps

module sdram_arbiter
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        new_frame_i,

	// loader master
	input  logic [pcm_pkg::ADDR_W-1:0]  ld_addr_i,
	input  logic                        ld_write_i,
	input  logic [pcm_pkg::DATA_W-1:0]  ld_wdata_i,
	input  logic                        ld_done_i,
	input  logic                        ld_cs_i,
	input  logic                        ld_sclk_i,
	input  logic                        ld_mosi_i,
	output logic                        ld_wait_o,
	output logic                        ld_ack_o,
	output logic                        ld_miso_o,

	// reader master
	input  logic [pcm_pkg::ADDR_W-1:0]  rd_addr_i,
	input  logic                        rd_read_i,
	input  logic                        rd_done_i,
	output logic                        rd_wait_o,
	output logic                        rd_ack_o,
	output logic [pcm_pkg::DATA_W-1:0]  rd_data_o,

	// external memory
	input  logic                        mem_ack_i,
	input  logic [pcm_pkg::DATA_W-1:0]  mem_rdata_i,
	output logic [pcm_pkg::ADDR_W-1:0]  mem_addr_o,
	output logic [1:0]                  mem_be_o,
	output logic                        mem_read_o,
	output logic                        mem_write_o,
	output logic [pcm_pkg::DATA_W-1:0]  mem_wdata_o,

	// host spi and card pins
	input  logic                        host_cs_n_i,
	input  logic                        host_sclk_i,
	input  logic                        host_mosi_i,
	output logic                        host_miso_o,
	input  logic                        sd_miso_i,
	output logic                        sd_cs_o,
	output logic                        sd_sclk_o,
	output logic                        sd_mosi_o
);

	pcm_pkg::phase_t phase_q;
	pcm_pkg::phase_t phase_d;

	always_ff @(posedge clk)
	begin
		if (reset)
			phase_q <= pcm_pkg::BOOTUP;
		else
			phase_q <= phase_d;
	end

	always_comb
	begin
		phase_d = phase_q;
		case (phase_q)
			pcm_pkg::BOOTUP:
				if (new_frame_i)
					phase_d = pcm_pkg::LOAD;
			pcm_pkg::LOAD:
				if (ld_done_i)
					phase_d = pcm_pkg::LOAD_DONE;
			pcm_pkg::LOAD_DONE:
				if (new_frame_i)
					phase_d = pcm_pkg::PLAY;
			pcm_pkg::PLAY:
				if (rd_done_i)
					phase_d = pcm_pkg::HALTED;
			pcm_pkg::HALTED:
				if (new_frame_i)
					phase_d = pcm_pkg::PLAY;	// replay from word 0
			default:
				phase_d = pcm_pkg::BOOTUP;
		endcase
	end

	// port routing, everything not owned sees wait high and no ack
	always_comb
	begin
		ld_wait_o = 1'b1;
		ld_ack_o = 1'b0;
		ld_miso_o = 1'b0;
		rd_wait_o = 1'b1;
		rd_ack_o = 1'b0;
		rd_data_o = mem_rdata_i;	// qualified by rd_ack_o

		mem_addr_o = rd_addr_i;
		mem_be_o = 2'b11;	// always whole words
		mem_read_o = 1'b0;
		mem_write_o = 1'b0;
		mem_wdata_o = ld_wdata_i;

		// host owns the card unless the loader is active
		sd_cs_o = host_cs_n_i;
		sd_sclk_o = host_sclk_i;
		sd_mosi_o = host_mosi_i;
		host_miso_o = sd_miso_i;

		case (phase_q)
			pcm_pkg::BOOTUP, pcm_pkg::LOAD:
			begin
				sd_cs_o = ld_cs_i;
				sd_sclk_o = ld_sclk_i;
				sd_mosi_o = ld_mosi_i;
				ld_miso_o = sd_miso_i;
				host_miso_o = 1'b0;	// host reads zeros while loading

				mem_addr_o = ld_addr_i;
				mem_write_o = ld_write_i;
				ld_ack_o = mem_ack_i;
				ld_wait_o = (phase_q == pcm_pkg::BOOTUP);	// released once loading starts
			end
			pcm_pkg::PLAY:
			begin
				rd_wait_o = 1'b0;
				mem_read_o = rd_read_i;
				rd_ack_o = mem_ack_i;
			end
			default:
			begin
				// load done or halted, memory stays idle
				mem_read_o = 1'b0;
			end
		endcase
	end

endmodule

/* logic/pcm_pkg.sv */
package pcm_pkg;

	// memory port
	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;	// memory word, also one pcm sample

	// block length, loaded once and replayed on every play
	localparam int LOAD_WORDS = 64;

	// clock dividers, in system clocks per half period
	localparam int SPI_DIV = 2;	// sd card sclk
	localparam int BCLK_DIV = 4;	// i2s bit clock

	// arbiter phases
	typedef enum logic [2:0]
	{
		BOOTUP,
		LOAD,
		LOAD_DONE,
		PLAY,
		HALTED
	} phase_t;

endpackage
